// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // access size as driven by the core
    typedef enum logic [1:0] {
        SZ_NONE = 2'b00,
        SZ_BYTE = 2'b01,
        SZ_HALF = 2'b10,
        SZ_WORD = 2'b11
    } mem_size_e;

    // axi-lite response codes, only the two we use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // on-chip sram window
    localparam logic [31:0] SRAM_BASE  = 32'h8000_0000;
    localparam int          SRAM_WORDS = 1024;
    localparam int          SRAM_AW    = $clog2(SRAM_WORDS);  // word index width

    // clint window
    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [31:0] CLINT_END  = 32'h0200_FFFF;

    // mtime register offsets inside the clint window
    localparam logic [15:0] MTIME_LO_OFF = 16'hBFF8;
    localparam logic [15:0] MTIME_HI_OFF = 16'hBFFC;

endpackage

`default_nettype wire

// File: logic/sram.sv
`timescale 1ns/1ps
`default_nettype none

module sram import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ar_valid,
    input  logic [31:0] ar_addr,
    output logic        ar_ready,
    output logic        r_valid,
    output logic [31:0] r_data,
    output resp_e       r_resp,
    input  logic        r_ready,
    input  logic        aw_valid,
    input  logic [31:0] aw_addr,
    output logic        aw_ready,
    input  logic        w_valid,
    input  logic [31:0] w_data,
    input  logic [3:0]  w_strb,
    output logic        w_ready,
    output logic        b_valid,
    output resp_e       b_resp,
    input  logic        b_ready
);

    logic [31:0] mem [SRAM_WORDS];

    logic [31:0] ar_off;
    logic [31:0] aw_off;
    logic        ar_hit;
    logic        aw_hit;
    logic        rd_fire;
    logic        wr_fire;

    // byte offsets into the window, upper bits zero means in range
    assign ar_off = ar_addr - SRAM_BASE;
    assign aw_off = aw_addr - SRAM_BASE;
    assign ar_hit = ar_off[31:SRAM_AW+2] == '0;
    assign aw_hit = aw_off[31:SRAM_AW+2] == '0;

    assign ar_ready = !r_valid;
    assign aw_ready = !b_valid;
    assign w_ready  = !b_valid;

    assign rd_fire = ar_valid && ar_ready;
    assign wr_fire = aw_valid && aw_ready && w_valid && w_ready;  // addr and data together

    always_ff @(posedge clk) begin
        if (!rst_n)
            r_valid <= 1'b0;
        else if (rd_fire)
            r_valid <= 1'b1;
        else if (r_ready)
            r_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            r_data <= ar_hit ? mem[ar_off[SRAM_AW+1:2]] : 32'h0;
            r_resp <= ar_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            b_valid <= 1'b0;
        else if (wr_fire)
            b_valid <= 1'b1;
        else if (b_ready)
            b_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (wr_fire)
            b_resp <= aw_hit ? RESP_OKAY : RESP_SLVERR;
    end

    // strobed byte write
    always_ff @(posedge clk) begin
        if (wr_fire && aw_hit) begin
            for (int i = 0; i < 4; i++) begin
                if (w_strb[i])
                    mem[aw_off[SRAM_AW+1:2]][i*8 +: 8] <= w_data[i*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/clint.sv
`timescale 1ns/1ps
`default_nettype none

module clint import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ar_valid,
    input  logic [31:0] ar_addr,
    output logic        ar_ready,
    output logic        r_valid,
    output logic [31:0] r_data,
    output resp_e       r_resp,
    input  logic        r_ready
);

    logic [63:0] mtime;
    logic        rd_fire;

    assign ar_ready = !r_valid;
    assign rd_fire  = ar_valid && ar_ready;

    always_ff @(posedge clk) begin
        if (!rst_n)
            mtime <= 64'h0;
        else
            mtime <= mtime + 64'd1;  // free running
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            r_valid <= 1'b0;
        else if (rd_fire)
            r_valid <= 1'b1;
        else if (r_ready)
            r_valid <= 1'b0;
    end

    // sample mtime on the accept edge
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (ar_addr[15:0])
                MTIME_LO_OFF: begin
                    r_data <= mtime[31:0];
                    r_resp <= RESP_OKAY;
                end
                MTIME_HI_OFF: begin
                    r_data <= mtime[63:32];
                    r_resp <= RESP_OKAY;
                end
                default: begin
                    r_data <= 32'h0;
                    r_resp <= RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic        wen,
    input  logic        ren,
    input  logic        sign,
    input  mem_size_e   size,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        done,
    output logic        err
);

    logic        is_clint;
    logic [3:0]  w_strb;
    logic [31:0] w_data;

    logic        ar_valid, ar_ready;
    logic        aw_valid, aw_ready;
    logic        w_valid, w_ready;
    logic        r_valid, r_ready;
    logic        b_valid, b_ready;
    resp_e       r_resp, b_resp;

    logic        sram_ar_ready, sram_r_valid, sram_aw_ready, sram_w_ready, sram_b_valid;
    logic [31:0] sram_r_data;
    resp_e       sram_r_resp, sram_b_resp;
    logic        clint_ar_ready, clint_r_valid;
    logic [31:0] clint_r_data;
    resp_e       clint_r_resp;

    logic        st_pend;   // store to clint, finishes next cycle
    logic        done_q;
    logic        err_q;
    logic [31:0] rmem;
    logic [31:0] rshift;

    assign is_clint = (addr >= CLINT_BASE) && (addr <= CLINT_END);

    always_comb begin
        case (size)
            SZ_BYTE: w_strb = 4'b0001 << addr[1:0];
            SZ_HALF: w_strb = addr[1] ? 4'b1100 : 4'b0011;
            SZ_WORD: w_strb = 4'b1111;
            default: w_strb = 4'b0000;
        endcase
    end

    assign w_data = wdata << {addr[1:0], 3'b000};  // move into byte lanes

    // route the selected target back
    assign ar_ready = is_clint ? clint_ar_ready : sram_ar_ready;
    assign r_valid  = is_clint ? clint_r_valid  : sram_r_valid;
    assign r_resp   = is_clint ? clint_r_resp   : sram_r_resp;
    assign aw_ready = is_clint ? 1'b0 : sram_aw_ready;
    assign w_ready  = is_clint ? 1'b0 : sram_w_ready;
    assign b_valid  = is_clint ? 1'b0 : sram_b_valid;
    assign b_resp   = sram_b_resp;  // only sram answers writes

    assign r_ready = 1'b1;
    assign b_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar_valid <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            st_pend  <= 1'b0;
        end else begin
            if (req && ren)
                ar_valid <= 1'b1;
            else if (ar_valid && ar_ready)
                ar_valid <= 1'b0;

            if (req && wen && !is_clint)
                aw_valid <= 1'b1;
            else if (aw_valid && aw_ready)
                aw_valid <= 1'b0;

            if (req && wen && !is_clint)
                w_valid <= 1'b1;
            else if (w_valid && w_ready)
                w_valid <= 1'b0;

            st_pend <= req && wen && is_clint;
        end
    end

    // completion and response capture
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end else if (r_valid && r_ready) begin
            done_q <= 1'b1;
            err_q  <= r_resp != RESP_OKAY;
        end else if (b_valid && b_ready) begin
            done_q <= 1'b1;
            err_q  <= b_resp != RESP_OKAY;
        end else if (st_pend) begin
            done_q <= 1'b1;
            err_q  <= 1'b1;  // clint is read-only
        end else begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (r_valid && r_ready)
            rmem <= is_clint ? clint_r_data : sram_r_data;
    end

    assign rshift = rmem >> {addr[1:0], 3'b000};

    always_comb begin
        case (size)
            SZ_BYTE: rdata = {{24{rshift[7] & sign}}, rshift[7:0]};
            SZ_HALF: rdata = {{16{rshift[15] & sign}}, rshift[15:0]};
            SZ_WORD: rdata = rshift;
            default: rdata = 32'h0;
        endcase
    end

    assign done = (wen || ren) ? done_q : req;  // no-op request finishes at once
    assign err  = err_q;

    sram u_sram (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid && !is_clint),
        .ar_addr  (addr),
        .ar_ready (sram_ar_ready),
        .r_valid  (sram_r_valid),
        .r_data   (sram_r_data),
        .r_resp   (sram_r_resp),
        .r_ready  (r_ready),
        .aw_valid (aw_valid && !is_clint),
        .aw_addr  (addr),
        .aw_ready (sram_aw_ready),
        .w_valid  (w_valid && !is_clint),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .w_ready  (sram_w_ready),
        .b_valid  (sram_b_valid),
        .b_resp   (sram_b_resp),
        .b_ready  (b_ready)
    );

    clint u_clint (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid && is_clint),
        .ar_addr  (addr),
        .ar_ready (clint_ar_ready),
        .r_valid  (clint_r_valid),
        .r_data   (clint_r_data),
        .r_resp   (clint_r_resp),
        .r_ready  (r_ready)
    );

endmodule

`default_nettype wire

// File: logic/mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic        wen,
    input  logic        ren,
    input  logic        sign,
    input  mem_size_e   size,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        done,
    output logic        err
);

    lsu u_lsu (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .wen   (wen),
        .ren   (ren),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err)
    );

endmodule

`default_nettype wire

// File: test/tb_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_top import lsu_pkg::*; ();

    typedef enum logic [1:0] {OP_LOAD, OP_STORE, OP_NONE} op_e;
    typedef enum logic [1:0] {RD_IGNORE, RD_EXACT, RD_MTIME} rd_check_e;

    typedef struct {
        op_e         op;
        mem_size_e   size;
        logic        sign;
        logic [31:0] addr;
        logic [31:0] wdata;
        rd_check_e   rd_check;
        logic [31:0] exp_rdata;
        logic        exp_err;
        int          exp_lat;   // cycles from first falling edge to done
        int          gap;       // idle cycles before the request
    } step_t;

    logic        clk;
    logic        rst_n;
    logic        req;
    logic        wen;
    logic        ren;
    logic        sign;
    mem_size_e   size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        done;
    logic        err;

    step_t       steps[$];
    logic [7:0]  shadow [int];  // byte offset into the sram window
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    logic        have_time;
    logic [31:0] last_time;
    time         last_t;
    time         issue_t;

    mem_top u_mem_top (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .wen   (wen),
        .ren   (ren),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // little endian bytes from the shadow, then zero or sign extension
    function automatic logic [31:0] load_expect(mem_size_e sz, logic sgn, int off);
        logic [31:0] w;
        case (sz)
            SZ_BYTE: w = {{24{sgn & shadow[off][7]}}, shadow[off]};
            SZ_HALF: w = {{16{sgn & shadow[off+1][7]}}, shadow[off+1], shadow[off]};
            default: w = {shadow[off+3], shadow[off+2], shadow[off+1], shadow[off]};
        endcase
        return w;
    endfunction

    task automatic add_step(op_e op, mem_size_e sz, logic sgn, logic [31:0] a, logic [31:0] d,
                            rd_check_e rc, logic [31:0] exp_d, logic exp_e, int lat, int gap);
        step_t s;
        s = '{op, sz, sgn, a, d, rc, exp_d, exp_e, lat, gap};
        steps.push_back(s);
    endtask

    task automatic add_store(mem_size_e sz, int off, logic [31:0] d);
        int nb;
        nb = (sz == SZ_BYTE) ? 1 : (sz == SZ_HALF) ? 2 : 4;
        for (int i = 0; i < nb; i++)
            shadow[off+i] = d[i*8 +: 8];  // only the addressed lanes change
        add_step(OP_STORE, sz, 1'b0, SRAM_BASE + off, d, RD_IGNORE, 32'h0, 1'b0, 3, 0);
    endtask

    task automatic add_load(mem_size_e sz, logic sgn, int off);
        add_step(OP_LOAD, sz, sgn, SRAM_BASE + off, 32'h0, RD_EXACT,
                 load_expect(sz, sgn, off), 1'b0, 3, 0);
    endtask

    task automatic build_table();
        int top;
        top = (SRAM_WORDS - 1) * 4;
        add_store(SZ_WORD, 'h00, lcg_next());
        add_store(SZ_WORD, top, lcg_next());
        add_load(SZ_WORD, 1'b0, 'h00);
        add_load(SZ_WORD, 1'b0, top);
        add_store(SZ_WORD, 'h20, lcg_next());
        for (int o = 0; o < 4; o++) begin
            add_store(SZ_BYTE, 'h20 + o, lcg_next());
            add_load(SZ_WORD, 1'b0, 'h20);
        end
        add_store(SZ_WORD, 'h24, lcg_next());
        for (int o = 0; o < 4; o += 2) begin
            add_store(SZ_HALF, 'h24 + o, lcg_next());
            add_load(SZ_WORD, 1'b0, 'h24);
        end
        // every byte msb set in one word, clear in the other
        add_store(SZ_WORD, 'h10, lcg_next() | 32'h8080_8080);
        add_store(SZ_WORD, 'h14, lcg_next() & 32'h7f7f_7f7f);
        for (int w = 'h10; w <= 'h14; w += 4) begin
            for (int o = 0; o < 4; o++) begin
                add_load(SZ_BYTE, 1'b0, w + o);
                add_load(SZ_BYTE, 1'b1, w + o);
            end
            for (int o = 0; o < 4; o += 2) begin
                add_load(SZ_HALF, 1'b0, w + o);
                add_load(SZ_HALF, 1'b1, w + o);
            end
        end
        add_step(OP_LOAD, SZ_WORD, 1'b0, {CLINT_BASE[31:16], MTIME_HI_OFF}, 32'h0, RD_EXACT,
                 32'h0, 1'b0, 3, 0);
        add_step(OP_LOAD, SZ_WORD, 1'b0, {CLINT_BASE[31:16], MTIME_LO_OFF}, 32'h0, RD_MTIME,
                 32'h0, 1'b0, 3, 0);
        add_step(OP_LOAD, SZ_WORD, 1'b0, {CLINT_BASE[31:16], MTIME_LO_OFF}, 32'h0, RD_MTIME,
                 32'h0, 1'b0, 3, 7);
        add_step(OP_LOAD, SZ_WORD, 1'b0, {CLINT_BASE[31:16], MTIME_LO_OFF}, 32'h0, RD_MTIME,
                 32'h0, 1'b0, 3, 30);
        add_step(OP_LOAD, SZ_WORD, 1'b0, SRAM_BASE + SRAM_WORDS * 4, 32'h0, RD_EXACT,
                 32'h0, 1'b1, 3, 0);
        add_step(OP_STORE, SZ_WORD, 1'b0, {CLINT_BASE[31:16], MTIME_LO_OFF}, lcg_next(),
                 RD_IGNORE, 32'h0, 1'b1, 2, 0);  // clint is read only
        add_load(SZ_WORD, 1'b0, 'h00);
        add_step(OP_NONE, SZ_NONE, 1'b0, SRAM_BASE, 32'h0, RD_IGNORE, 32'h0, 1'b0, 0, 2);
        add_load(SZ_WORD, 1'b0, top);
    endtask

    task automatic check_word(string name, logic [31:0] act, logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic act, logic exp);
        checks++;
        if (act !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic apply_step(int idx);
        step_t s;
        int    waited;
        s = steps[idx];
        repeat (s.gap) @(posedge clk);
        @(posedge clk);
        req     <= 1'b1;
        wen     <= (s.op == OP_STORE);
        ren     <= (s.op == OP_LOAD);
        sign    <= s.sign;
        size    <= s.size;
        addr    <= s.addr;
        wdata   <= s.wdata;
        issue_t = $time;
        waited  = 0;
        @(negedge clk);
        while (!done && waited < 20) begin
            @(posedge clk);
            req <= 1'b0;  // one cycle request
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("step %0d: done did not rise within 20 cycles", idx);
            errors++;
        end else begin
            if (waited != s.exp_lat) begin
                $display("step %0d: done came after %0d cycles instead of %0d",
                         idx, waited, s.exp_lat);
                errors++;
            end
            check_flag("err", err, s.exp_err);
            if (s.rd_check == RD_EXACT) begin
                check_word("rdata", rdata, s.exp_rdata);
            end else if (s.rd_check == RD_MTIME) begin
                if (have_time)
                    check_word("mtime delta", rdata - last_time,
                               32'((issue_t - last_t) / 64'd20));
                have_time = 1'b1;
                last_time = rdata;
                last_t    = issue_t;
            end
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_flag("done", done, 1'b0);  // single cycle pulse
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        have_time = 1'b0;
        lcg_state = 32'd84003;
        rst_n     <= 1'b0;
        req       <= 1'b0;
        wen       <= 1'b0;
        ren       <= 1'b0;
        sign      <= 1'b0;
        size      <= SZ_NONE;
        addr      <= 32'h0;
        wdata     <= 32'h0;
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < steps.size(); i++)
            apply_step(i);
        $display("steps: %0d, checks: %0d, errors: %0d", steps.size(), checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
logic/lsu_pkg.sv
logic/sram.sv
logic/clint.sv
logic/lsu.sv
logic/mem_top.sv
test/tb_mem_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_mem_top \
    -f compile.f \
    -o sim_mem_top

output=$(./obj_dir/sim_mem_top)
echo "$output"

if grep -q "Result: PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
